/* verilog/sdram_test_macros.svh */
`ifndef SDRAM_TEST_MACROS_SVH
`define SDRAM_TEST_MACROS_SVH

////////////////////////////////////////
// UART timing.
////////////////////////////////////////

// 133.33 MHz / 115200 baud, rounded.
`define SDRAM_TEST_BAUD_DIV 1157

// Idle gap between passes, in clock cycles.
`define SDRAM_TEST_PAUSE_CYCLES 2222222

////////////////////////////////////////
// SDRAM test pattern geometry.
////////////////////////////////////////

`define SDRAM_TEST_BURST_WORDS 4   // Words per burst.
`define SDRAM_TEST_ADDR_STEP 4     // One burst further.
`define SDRAM_TEST_ADDR_LAST 383996 // Last burst of a 480x800 frame.

`endif

/* verilog/sdram_bus_pkg.sv */
`include "sdram_test_macros.svh"

// Types for the request/done burst port of the SDRAM controller.
package sdram_bus_pkg;

    ////////////////////////////////////////
    // Basic data types.
    ////////////////////////////////////////

    typedef logic [15:0] word_t; // One SDRAM word.

    // Bank(2) + row(13) + column(9).
    typedef logic [23:0] addr_t;

    // Four words, word 0 in the low bits.
    typedef word_t [`SDRAM_TEST_BURST_WORDS-1:0] burst_t;

    ////////////////////////////////////////
    // Port structs.
    ////////////////////////////////////////

    // Request side, driven towards the controller.
    typedef struct packed {
        logic   wr_req;  // Write level, held until wr_done.
        logic   rd_req;  // Read level, held until rd_done.
        addr_t  addr;    // Burst start address.
        burst_t wr_data; // Burst to be written.
    } mem_req_t;

    // Response side, from the controller.
    typedef struct packed {
        logic   wr_done; // One-cycle pulse.
        logic   rd_done; // One-cycle pulse, rd_data valid.
        burst_t rd_data; // Burst read back.
    } mem_rsp_t;

endpackage

/* verilog/sdram_test_pkg.sv */
`include "sdram_test_macros.svh"

// Sequencer states and UART framing for the SDRAM self-test.
package sdram_test_pkg;

    ////////////////////////////////////////
    // Sequencer states.
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        ST_BURST,      // Kick the burst port.
        ST_WAIT_BURST, // Write then read in flight.
        ST_CHECK,      // Compare one word.
        ST_SEND_HI,    // Queue high byte.
        ST_SEND_LO,    // Queue low byte.
        ST_PAUSE,      // Gap between passes.
        ST_DONE,       // Last address passed.
        ST_HALT        // Mismatch seen.
    } test_state_e;

    // Word index inside one burst.
    localparam int WORD_IDX_W = $clog2(`SDRAM_TEST_BURST_WORDS);

    ////////////////////////////////////////
    // UART frame.
    ////////////////////////////////////////

    localparam int UART_FRAME_BITS = 11; // Start + 8 data + 2 stop.
    localparam int UART_STOP_BITS  = 2;

endpackage

/* verilog/sdram_burst_port.sv */
`timescale 1ns/1ps
`include "sdram_test_macros.svh"

// Write-then-read burst engine on the SDRAM request/done port.
// Keeps the current address and the test pattern.
module sdram_burst_port #(
    parameter int unsigned ADDR_LAST = `SDRAM_TEST_ADDR_LAST
) (
    input  logic                    clk_133MHz_210,
    input  logic                    rst_n,
    input  logic                    start,      // Pulse, begins one burst.
    input  logic                    advance,    // Pulse, next address and data.
    output sdram_bus_pkg::mem_req_t mem_req,
    input  sdram_bus_pkg::mem_rsp_t mem_rsp,
    output sdram_bus_pkg::burst_t   pattern,    // Burst being written.
    output sdram_bus_pkg::burst_t   readback,   // Burst last read.
    output logic                    burst_done, // Pulse after rd_done.
    output logic                    at_last     // Address is ADDR_LAST.
);

    import sdram_bus_pkg::*;

    ////////////////////////////////////////
    // Phase machine.
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_WRITE,
        PH_READ
    } phase_e;

    phase_e phase;
    addr_t  addr_q;
    burst_t data_q;

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= PH_IDLE;
            burst_done <= 1'b0;
        end else begin
            burst_done <= 1'b0; // Default, pulse only.
            case (phase)
                PH_IDLE: begin
                    if (start) begin
                        phase <= PH_WRITE; // Write level up next cycle.
                    end
                end
                PH_WRITE: begin
                    // Drop write, raise read on the same edge.
                    if (mem_rsp.wr_done) begin
                        phase <= PH_READ;
                    end
                end
                PH_READ: begin
                    if (mem_rsp.rd_done) begin
                        phase      <= PH_IDLE;
                        burst_done <= 1'b1;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // Readback latched on the read-done pulse.
    always_ff @(posedge clk_133MHz_210) begin
        if (phase == PH_READ && mem_rsp.rd_done) begin
            readback <= mem_rsp.rd_data;
        end
    end

    ////////////////////////////////////////
    // Address and data pattern.
    ////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
            data_q <= '0;
        end else if (advance) begin
            addr_q <= addr_q + addr_t'(`SDRAM_TEST_ADDR_STEP);
            // Every word goes up by one.
            for (int w = 0; w < `SDRAM_TEST_BURST_WORDS; w++) begin
                data_q[w] <= data_q[w] + word_t'(1);
            end
        end
    end

    // Levels follow the phase, so write and read never overlap.
    assign mem_req = '{
        wr_req:  (phase == PH_WRITE),
        rd_req:  (phase == PH_READ),
        addr:    addr_q,
        wr_data: data_q
    };

    assign pattern = data_q;
    assign at_last = (addr_q == addr_t'(ADDR_LAST)); // End of the frame.

endmodule

/* verilog/uart_frame_tx.sv */
`timescale 1ns/1ps
`include "sdram_test_macros.svh"

// One-byte UART transmitter, 8 data bits LSB first, two stop bits.
module uart_frame_tx #(
    parameter int unsigned BAUD_DIV = `SDRAM_TEST_BAUD_DIV
) (
    input  logic       clk_133MHz_210,
    input  logic       rst_n,
    input  logic       send,     // Pulse, only while not busy.
    input  logic [7:0] tx_byte,
    output logic       busy,
    output logic       uart_txd  // Idles high.
);

    import sdram_test_pkg::*;

    localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
    localparam int IDX_W = $clog2(UART_FRAME_BITS);

    logic [UART_FRAME_BITS-1:0] frame_q;  // Bit 0 is on the line.
    logic [CNT_W-1:0]           baud_cnt;
    logic [IDX_W-1:0]           bit_idx;
    logic                       baud_tick;

    assign baud_tick = (baud_cnt == CNT_W'(BAUD_DIV - 1)); // Bit period over.

    ////////////////////////////////////////
    // Frame shifter.
    ////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            frame_q  <= '1; // Line high.
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else if (!busy) begin
            if (send) begin
                // Stop bits, data, start bit.
                frame_q  <= {{UART_STOP_BITS{1'b1}}, tx_byte, 1'b0};
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_idx  <= '0;
            end
        end else if (baud_tick) begin
            baud_cnt <= '0;
            frame_q  <= {1'b1, frame_q[UART_FRAME_BITS-1:1]}; // Refill with idle.
            if (bit_idx == IDX_W'(UART_FRAME_BITS - 1)) begin
                busy <= 1'b0; // Last stop bit done.
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign uart_txd = frame_q[0];

endmodule

/* verilog/sdram_test_seq.sv */
`timescale 1ns/1ps
`include "sdram_test_macros.svh"

// Self-test sequencer. Checks each word of the readback, reports
// matching words over UART and stops on the first mismatch.
module sdram_test_seq #(
    parameter int unsigned PAUSE_CYCLES = `SDRAM_TEST_PAUSE_CYCLES
) (
    input  logic                  clk_133MHz_210,
    input  logic                  rst_n,
    input  logic                  burst_done, // Pulse from the burst port.
    input  sdram_bus_pkg::burst_t pattern,    // Expected words.
    input  sdram_bus_pkg::burst_t readback,   // Words read back.
    input  logic                  at_last,
    input  logic                  tx_busy,
    output logic                  start,      // Pulse, one burst.
    output logic                  advance,    // Pulse, next pass.
    output logic                  send,       // Pulse to the UART.
    output logic [7:0]            tx_byte,
    output logic                  error_led,
    output logic                  run_done
);

    import sdram_bus_pkg::*;
    import sdram_test_pkg::*;

    test_state_e           state;
    logic [WORD_IDX_W-1:0] word_idx;  // Word under test.
    logic [31:0]           pause_cnt;
    word_t                 cur_word;
    logic                  word_ok;
    logic                  last_word;
    logic                  pause_end;

    ////////////////////////////////////////
    // Word selection and compare.
    ////////////////////////////////////////

    assign cur_word  = readback[word_idx];
    assign word_ok   = (cur_word == pattern[word_idx]);
    assign last_word = (word_idx == WORD_IDX_W'(`SDRAM_TEST_BURST_WORDS - 1));
    assign pause_end = (pause_cnt == 32'(PAUSE_CYCLES));

    ////////////////////////////////////////
    // State machine.
    ////////////////////////////////////////

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_BURST;
            word_idx  <= '0;
            pause_cnt <= '0;
        end else begin
            case (state)
                ST_BURST: begin
                    word_idx <= '0; // Start pulses here.
                    state    <= ST_WAIT_BURST;
                end
                ST_WAIT_BURST: begin
                    if (burst_done) begin
                        state <= ST_CHECK;
                    end
                end
                ST_CHECK: begin
                    // First mismatch stops the run.
                    state <= word_ok ? ST_SEND_HI : ST_HALT;
                end
                ST_SEND_HI: begin
                    if (!tx_busy) begin
                        state <= ST_SEND_LO; // Busy is up by then.
                    end
                end
                ST_SEND_LO: begin
                    if (!tx_busy) begin
                        if (last_word) begin
                            pause_cnt <= '0;
                            state     <= ST_PAUSE;
                        end else begin
                            word_idx <= word_idx + 1'b1;
                            state    <= ST_CHECK;
                        end
                    end
                end
                ST_PAUSE: begin
                    if (pause_end) begin
                        // Advance pulses on the way back.
                        state <= at_last ? ST_DONE : ST_BURST;
                    end else begin
                        pause_cnt <= pause_cnt + 1'b1;
                    end
                end
                ST_DONE, ST_HALT: begin
                    state <= state; // Held until reset.
                end
                default: state <= ST_HALT;
            endcase
        end
    end

    ////////////////////////////////////////
    // Outputs, decoded from the state.
    ////////////////////////////////////////

    assign start   = (state == ST_BURST);
    assign advance = (state == ST_PAUSE) && pause_end && !at_last;
    assign send    = ((state == ST_SEND_HI) || (state == ST_SEND_LO)) && !tx_busy;

    // High byte first.
    assign tx_byte = (state == ST_SEND_HI) ? cur_word[15:8] : cur_word[7:0];

    assign error_led = (state == ST_HALT);
    assign run_done  = (state == ST_DONE);

endmodule

/* verilog/sdram_selftest_top.sv */
`timescale 1ns/1ps
`include "sdram_test_macros.svh"

// SDRAM self-test top level.
// Burst port towards the controller, sequencer, UART report line.
module sdram_selftest_top #(
    parameter int unsigned BAUD_DIV     = `SDRAM_TEST_BAUD_DIV,
    parameter int unsigned PAUSE_CYCLES = `SDRAM_TEST_PAUSE_CYCLES,
    parameter int unsigned ADDR_LAST    = `SDRAM_TEST_ADDR_LAST
) (
    input  logic                    clk_133MHz_210,
    input  logic                    rst_n,
    output sdram_bus_pkg::mem_req_t mem_req,   // To the SDRAM controller.
    input  sdram_bus_pkg::mem_rsp_t mem_rsp,   // From the SDRAM controller.
    output logic                    uart_txd,
    output logic                    error_led, // Mismatch found.
    output logic                    run_done   // Last address passed.
);

    import sdram_bus_pkg::*;

    ////////////////////////////////////////
    // Internal wiring.
    ////////////////////////////////////////

    logic       start;
    logic       advance;
    burst_t     pattern;
    burst_t     readback;
    logic       burst_done;
    logic       at_last;
    logic       send;
    logic [7:0] tx_byte;
    logic       tx_busy;

    sdram_burst_port #(
        .ADDR_LAST (ADDR_LAST)
    ) u_burst_port (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .start          (start),
        .advance        (advance),
        .mem_req        (mem_req),
        .mem_rsp        (mem_rsp),
        .pattern        (pattern),
        .readback       (readback),
        .burst_done     (burst_done),
        .at_last        (at_last)
    );

    sdram_test_seq #(
        .PAUSE_CYCLES (PAUSE_CYCLES)
    ) u_seq (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .burst_done     (burst_done),
        .pattern        (pattern),
        .readback       (readback),
        .at_last        (at_last),
        .tx_busy        (tx_busy),
        .start          (start),
        .advance        (advance),
        .send           (send),
        .tx_byte        (tx_byte),
        .error_led      (error_led),
        .run_done       (run_done)
    );

    uart_frame_tx #(
        .BAUD_DIV (BAUD_DIV)
    ) u_uart_tx (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .send           (send),
        .tx_byte        (tx_byte),
        .busy           (tx_busy),
        .uart_txd       (uart_txd)
    );

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

// Free-running testbench clock and an active-low reset pulse on request.
module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 2
) (
    input  logic reset_req,      // Rising edge starts a reset.
    output logic clk_133MHz_210,
    output logic rst_n
);

    initial begin
        clk_133MHz_210 = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_133MHz_210 = ~clk_133MHz_210;
    end

    // Held in reset until the first request.
    initial begin
        rst_n = 1'b0;
        forever begin
            @(posedge reset_req);
            rst_n = 1'b0;
            repeat (RESET_CYCLES) @(posedge clk_133MHz_210);
            @(negedge clk_133MHz_210);
            rst_n = 1'b1; // Released between edges.
        end
    end

endmodule

/* tests/sdram_selftest_checker.sv */
`timescale 1ns/1ps

// Protocol and status assertions on the self-test top level.
module sdram_selftest_checker (
    input logic                    clk_133MHz_210,
    input logic                    rst_n,
    input sdram_bus_pkg::mem_req_t mem_req,
    input sdram_bus_pkg::mem_rsp_t mem_rsp,
    input logic                    tx_busy,
    input logic                    uart_txd,
    input logic                    error_led,
    input logic                    run_done
);

    int unsigned assert_fails = 0; // Assertion failures so far.

    ////////////////////////////////////////
    // Memory port.
    ////////////////////////////////////////

    // Write and read never overlap.
    req_exclusive: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !(mem_req.wr_req && mem_req.rd_req))
    else begin
        assert_fails++;
        $error("wr_req and rd_req high together");
    end

    // Write level, address and data held until wr_done.
    wr_held: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        mem_req.wr_req && !mem_rsp.wr_done |=>
            mem_req.wr_req && $stable(mem_req.addr) && $stable(mem_req.wr_data))
    else begin
        assert_fails++;
        $error("wr_req dropped or changed before wr_done");
    end

    rd_held: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        mem_req.rd_req && !mem_rsp.rd_done |=> mem_req.rd_req && $stable(mem_req.addr))
    else begin
        assert_fails++;
        $error("rd_req dropped or changed before rd_done");
    end

    ////////////////////////////////////////
    // Status and UART line.
    ////////////////////////////////////////

    status_exclusive: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !(error_led && run_done))
    else begin
        assert_fails++;
        $error("error_led and run_done high together");
    end

    line_idle: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !tx_busy |-> uart_txd)
    else begin
        assert_fails++;
        $error("uart_txd low while the transmitter is idle");
    end

endmodule

bind sdram_selftest_top sdram_selftest_checker u_checker (
    .clk_133MHz_210 (clk_133MHz_210),
    .rst_n          (rst_n),
    .mem_req        (mem_req),
    .mem_rsp        (mem_rsp),
    .tx_busy        (tx_busy),
    .uart_txd       (uart_txd),
    .error_led      (error_led),
    .run_done       (run_done)
);

/* tests/sdram_selftest_tb.sv */
`timescale 1ns/1ps

// SDRAM self-test testbench. Memory model, UART receiver, fault table.
module sdram_selftest_tb;

    import sdram_bus_pkg::*;

    localparam int BAUD_DIV     = 8;
    localparam int PAUSE_CYCLES = 20;
    localparam int ADDR_LAST    = 12;
    localparam int PASSES       = ADDR_LAST / 4 + 1; // Addresses 0, 4, 8, 12.
    localparam int FRAME_CYCLES = 11 * BAUD_DIV;
    localparam int NUM_ROWS     = 6;
    localparam int TIMEOUT = NUM_ROWS * 4 * (8 * FRAME_CYCLES + PAUSE_CYCLES + 40) * 2;

    // One table row.
    typedef struct packed {
        logic       has_fault;
        logic [1:0] fault_pass;
        logic [1:0] fault_word;
        word_t      fault_mask;  // Bits flipped in the readback.
    } row_t;

    logic        clk_133MHz_210;
    logic        rst_n;
    logic        reset_req;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    logic        uart_txd;
    logic        error_led;
    logic        run_done;
    row_t        rows [NUM_ROWS];
    row_t        cur;            // Row under test.
    burst_t      mem_array [16];
    integer      seed = 32'h9213;
    int          rd_count;       // Reads served, one per pass.
    int          frame_errors;
    int          row_errors;
    int          errors;
    int          rows_failed;
    int unsigned cycle_count;
    logic [7:0]  rx_bytes [$];
    logic [7:0]  exp_bytes [$];
    addr_t       wr_addrs [$];
    burst_t      wr_bursts [$];

    tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(2)) u_clock_gen (
        .reset_req      (reset_req),
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n)
    );

    sdram_selftest_top #(
        .BAUD_DIV     (BAUD_DIV),
        .PAUSE_CYCLES (PAUSE_CYCLES),
        .ADDR_LAST    (ADDR_LAST)
    ) u_sdram_selftest_top (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .mem_req        (mem_req),
        .mem_rsp        (mem_rsp),
        .uart_txd       (uart_txd),
        .error_led      (error_led),
        .run_done       (run_done)
    );

    ////////////////////////////////////////
    // Memory model and UART receiver.
    ////////////////////////////////////////

    // Done pulse 1 to 6 cycles after the request.
    initial begin : memory_model
        int delay;
        mem_rsp = '0;
        forever begin
            @(negedge clk_133MHz_210);
            if (rst_n && (mem_req.wr_req || mem_req.rd_req)) begin
                delay = 1 + int'($unsigned($random(seed)) % 6);
                repeat (delay - 1) @(negedge clk_133MHz_210);
                if (mem_req.wr_req) begin
                    mem_array[mem_req.addr[5:2]] = mem_req.wr_data;
                    wr_addrs.push_back(mem_req.addr);
                    wr_bursts.push_back(mem_req.wr_data);
                    mem_rsp.wr_done = 1'b1;
                end else begin
                    mem_rsp.rd_data = mem_array[mem_req.addr[5:2]];
                    if (cur.has_fault && rd_count == int'(cur.fault_pass)) begin
                        mem_rsp.rd_data[cur.fault_word] ^= cur.fault_mask; // Injected fault.
                    end
                    rd_count++;
                    mem_rsp.rd_done = 1'b1;
                end
                @(negedge clk_133MHz_210);
                mem_rsp.wr_done = 1'b0;
                mem_rsp.rd_done = 1'b0;
            end
        end
    end

    // Samples mid-bit, LSB first.
    initial begin : uart_receiver
        logic [7:0] data;
        forever begin
            @(negedge clk_133MHz_210);
            if (rst_n === 1'b1 && uart_txd === 1'b0) begin
                repeat (BAUD_DIV / 2) @(negedge clk_133MHz_210);
                if (uart_txd !== 1'b0) begin
                    frame_errors++; // Glitch, not a start bit.
                end
                for (int b = 0; b < 8; b++) begin
                    repeat (BAUD_DIV) @(negedge clk_133MHz_210);
                    data[b] = uart_txd;
                end
                for (int s = 0; s < 2; s++) begin
                    repeat (BAUD_DIV) @(negedge clk_133MHz_210);
                    if (uart_txd !== 1'b1) begin
                        frame_errors++;
                    end
                end
                rx_bytes.push_back(data);
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT) begin
            @(posedge clk_133MHz_210);
            cycle_count++;
        end
        $display("timeout: run still going after %0d cycles", TIMEOUT);
        $display("** FAIL **");
        $finish;
    end

    ////////////////////////////////////////
    // Checks.
    ////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        row_errors++;
    endtask

    task automatic run_row(input int r);
        int npass;
        int late_reqs;
        cur        = rows[r];
        row_errors = 0;
        late_reqs  = 0;
        @(negedge clk_133MHz_210);
        reset_req = 1'b1;
        rd_count     = 0;
        frame_errors = 0;
        rx_bytes.delete();
        exp_bytes.delete();
        wr_addrs.delete();
        wr_bursts.delete();
        @(posedge rst_n);
        reset_req = 1'b0;
        if ({uart_txd, mem_req.wr_req, mem_req.rd_req, error_led, run_done} !== 5'b10000) begin
            report_mismatch("{uart_txd,wr_req,rd_req,error_led,run_done}",
                            {uart_txd, mem_req.wr_req, mem_req.rd_req, error_led, run_done},
                            5'b10000);
        end
        // Pass p writes word value p, sent high byte then low byte.
        npass = cur.has_fault ? int'(cur.fault_pass) + 1 : PASSES;
        for (int p = 0; p < npass; p++) begin
            for (int w = 0; w < 4; w++) begin
                if (!(cur.has_fault && p == npass - 1 && w >= int'(cur.fault_word))) begin
                    exp_bytes.push_back(8'(p >> 8));
                    exp_bytes.push_back(8'(p & 'hFF));
                end
            end
        end
        while (!(run_done || error_led)) @(negedge clk_133MHz_210);
        // Let the last frame finish. The bus must stay quiet.
        repeat (2 * FRAME_CYCLES) begin
            @(negedge clk_133MHz_210);
            if (mem_req.wr_req || mem_req.rd_req) begin
                late_reqs++;
            end
        end
        if (late_reqs != 0) begin
            $display("memory requests seen after the end of the run");
            row_errors++;
        end
        if ({error_led, run_done} !== (cur.has_fault ? 2'b10 : 2'b01)) begin
            report_mismatch("{error_led,run_done}", {error_led, run_done},
                            cur.has_fault ? 2'b10 : 2'b01);
        end
        if (rx_bytes.size() != exp_bytes.size()) begin
            report_mismatch("uart byte count", rx_bytes.size(), exp_bytes.size());
        end
        foreach (exp_bytes[i]) begin
            if (i < rx_bytes.size() && rx_bytes[i] !== exp_bytes[i]) begin
                report_mismatch($sformatf("uart_txd byte %0d", i), rx_bytes[i], exp_bytes[i]);
            end
        end
        if (frame_errors != 0) begin
            $display("%0d UART frames had a bad start or stop bit", frame_errors);
            row_errors++;
        end
        if (wr_addrs.size() != npass) begin
            report_mismatch("write burst count", wr_addrs.size(), npass);
        end
        foreach (wr_addrs[i]) begin
            if (wr_addrs[i] !== addr_t'(4 * i)) begin
                report_mismatch($sformatf("mem_req.addr write %0d", i), wr_addrs[i], 4 * i);
            end
            if (wr_bursts[i] !== {4{word_t'(i)}}) begin
                report_mismatch($sformatf("mem_req.wr_data write %0d", i), wr_bursts[i],
                                {4{word_t'(i)}});
            end
        end
        $display("row %0d %s: %0d bytes, %0d errors", r,
                 cur.has_fault ? "fault" : "clean", rx_bytes.size(), row_errors);
        errors += row_errors;
        if (row_errors != 0) begin
            rows_failed++;
        end
    endtask

    initial begin : main
        reset_req   = 1'b0;
        errors      = 0;
        rows_failed = 0;
        rows[0] = '{1'b0, 2'd0, 2'd0, 16'h0000}; // Clean run.
        rows[1] = '{1'b1, 2'd1, 2'd2, 16'h0004}; // Word 2 of pass 1.
        rows[2] = '{1'b1, 2'd0, 2'd0, 16'h8000}; // Very first word.
        rows[3] = '{1'b0, 2'd0, 2'd0, 16'h0000}; // Clean, other latencies.
        rows[4] = '{1'b1, 2'd3, 2'd3, 16'h00ff}; // Last word of the run.
        rows[5] = '{1'b1, 2'd2, 2'd1, 16'h1000};
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        errors += u_sdram_selftest_top.u_checker.assert_fails;
        $display("rows %0d, failed %0d, errors %0d", NUM_ROWS, rows_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verilog
verilog/sdram_bus_pkg.sv
verilog/sdram_test_pkg.sv
verilog/sdram_burst_port.sv
verilog/uart_frame_tx.sv
verilog/sdram_test_seq.sv
verilog/sdram_selftest_top.sv
tests/tb_clock_gen.sv
tests/sdram_selftest_checker.sv
tests/sdram_selftest_tb.sv

/* Bender.yml */
package:
  name: sdram_selftest

export_include_dirs:
  - verilog

sources:
  - verilog/sdram_bus_pkg.sv
  - verilog/sdram_test_pkg.sv
  - verilog/sdram_burst_port.sv
  - verilog/uart_frame_tx.sv
  - verilog/sdram_test_seq.sv
  - verilog/sdram_selftest_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/sdram_selftest_checker.sv
      - tests/sdram_selftest_tb.sv
